// File: hdl/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// datapath and pc width
`define EX_XLEN       32

// destination register address width
`define EX_REG_AW     5

`define EX_INST_BYTES 4   // sequential pc step

// one quotient bit per iteration
`define EX_DIV_ITERS  32

`endif

// File: hdl/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]   word_t;
    typedef logic [`EX_REG_AW-1:0] reg_addr_t;

    // opcodes seen by both lanes
    typedef enum logic [4:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,    // signed compare
        SLTU,
        SLL,
        SRL,
        SRA,
        BEQ,
        BNE,
        BLT,    // signed compare
        JAL,    // links pc + 4
        DIVU,   // lane 1 only
        REMU    // lane 1 only
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } div_state_e;

endpackage

// File: hdl/alu_lane.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_lane (
    input  ex_pkg::word_t   pc_i,
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   src1_i,
    input  ex_pkg::word_t   src2_i,
    input  ex_pkg::word_t   imm_i,
    input  logic            valid_i,
    input  logic            pred_taken_i,
    input  ex_pkg::word_t   pred_target_i,
    output ex_pkg::word_t   result_o,
    output ex_pkg::word_t   next_pc_o,
    output ex_pkg::word_t   target_o,
    output logic            redirect_o
);

    import ex_pkg::*;

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    word_t              seq_pc;
    logic [SHAMT_W-1:0] shamt;
    logic               is_branch;
    logic               taken;
    logic               target_miss;

    assign seq_pc   = pc_i + word_t'(`EX_INST_BYTES);
    assign target_o = pc_i + imm_i;
    assign shamt    = src2_i[SHAMT_W-1:0];

    always_comb
    begin
        result_o  = '0;
        is_branch = 1'b0;
        taken     = 1'b0;
        case (op_i)
            ADD:  result_o = src1_i + src2_i;
            SUB:  result_o = src1_i - src2_i;
            AND:  result_o = src1_i & src2_i;
            OR:   result_o = src1_i | src2_i;
            XOR:  result_o = src1_i ^ src2_i;
            SLT:  result_o = word_t'($signed(src1_i) < $signed(src2_i));
            SLTU: result_o = word_t'(src1_i < src2_i);
            SLL:  result_o = src1_i << shamt;
            SRL:  result_o = src1_i >> shamt;
            SRA:  result_o = word_t'($signed(src1_i) >>> shamt);
            BEQ:
            begin
                is_branch = 1'b1;
                taken     = (src1_i == src2_i);
            end
            BNE:
            begin
                is_branch = 1'b1;
                taken     = (src1_i != src2_i);
            end
            BLT:
            begin
                is_branch = 1'b1;
                taken     = ($signed(src1_i) < $signed(src2_i));
            end
            JAL:
            begin
                is_branch = 1'b1;
                taken     = 1'b1;
                result_o  = seq_pc;   // link value
            end
            default: result_o = '0;   // nop, and divides finish outside the lane
        endcase
    end

    assign next_pc_o = taken ? target_o : seq_pc;

    // a correctly predicted taken branch must also have hit the right target
    assign target_miss = taken && (target_o != pred_target_i);
    assign redirect_o  = valid_i && is_branch && ((taken != pred_taken_i) || target_miss);

endmodule

// File: hdl/div_fsm.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module div_fsm (
    input  logic clk,
    input  logic rst_i,
    input  logic div_req_i,
    input  logic last_i,
    input  logic pause_mem_i,
    output logic start_o,
    output logic step_o,
    output logic done_o,
    output logic pause_o
);

    import ex_pkg::*;

    div_state_e state_q;
    div_state_e state_d;

    always_ff @(posedge clk)
    begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (div_req_i)
                    state_d = BUSY;
            BUSY:
                if (last_i)
                    state_d = DONE;
            DONE:
                if (!pause_mem_i)   // wait until mem takes the result
                    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign start_o = (state_q == IDLE) && div_req_i;
    assign step_o  = (state_q == BUSY);
    assign done_o  = (state_q == DONE);

    // stage stalls from arrival until the result cycle
    assign pause_o = div_req_i && (state_q != DONE);

endmodule

// File: hdl/div_counter.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module div_counter (
    input  logic clk,
    input  logic rst_i,
    input  logic load_i,
    input  logic step_i,
    output logic last_o
);

    localparam int CNT_W = $clog2(`EX_DIV_ITERS);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk)
    begin
        if (rst_i)
            cnt_q <= '0;
        else if (load_i)
            cnt_q <= CNT_W'(`EX_DIV_ITERS - 1);
        else if (step_i)
            cnt_q <= cnt_q - 1'b1;
    end

    // only meaningful while the fsm is stepping
    assign last_o = (cnt_q == '0);

endmodule

// File: hdl/div_datapath.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module div_datapath (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          start_i,
    input  logic          step_i,
    input  ex_pkg::word_t dividend_i,
    input  ex_pkg::word_t divisor_i,
    output ex_pkg::word_t quotient_o,
    output ex_pkg::word_t remainder_o
);

    import ex_pkg::*;

    word_t            rem_q;
    word_t            quo_q;   // dividend bits shift out, quotient bits shift in
    word_t            dvsr_q;
    logic [`EX_XLEN:0] shifted;
    logic [`EX_XLEN:0] diff;
    logic              fits;

    // bring down the next dividend bit and try the subtract
    assign shifted = {rem_q, quo_q[`EX_XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};
    assign fits    = ~diff[`EX_XLEN];

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            rem_q  <= '0;
            quo_q  <= '0;
            dvsr_q <= '0;
        end
        else if (start_i)
        begin
            rem_q  <= '0;
            quo_q  <= dividend_i;
            dvsr_q <= divisor_i;
        end
        else if (step_i)
        begin
            // a zero divisor always fits, giving all ones and rem = dividend
            if (fits)
                rem_q <= diff[`EX_XLEN-1:0];
            else
                rem_q <= shifted[`EX_XLEN-1:0];
            quo_q <= {quo_q[`EX_XLEN-2:0], fits};
        end
    end

    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

// File: hdl/ex_mem_reg.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_mem_reg (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              flush_i,
    input  logic              pause_mem_i,
    input  logic              pause_ex_i,
    input  logic              squash2_i,
    input  logic [1:0]        valid_i,
    input  ex_pkg::word_t     pc1_i,
    input  ex_pkg::word_t     pc2_i,
    input  ex_pkg::alu_op_e   op1_i,
    input  ex_pkg::alu_op_e   op2_i,
    input  ex_pkg::reg_addr_t rd1_i,
    input  ex_pkg::reg_addr_t rd2_i,
    input  logic              we1_i,
    input  logic              we2_i,
    input  ex_pkg::word_t     wdata1_i,
    input  ex_pkg::word_t     wdata2_i,
    output logic [1:0]        valid_mem_o,
    output logic [1:0]        we_mem_o,
    output ex_pkg::word_t     pc1_mem_o,
    output ex_pkg::word_t     pc2_mem_o,
    output ex_pkg::alu_op_e   op1_mem_o,
    output ex_pkg::alu_op_e   op2_mem_o,
    output ex_pkg::reg_addr_t rd1_mem_o,
    output ex_pkg::reg_addr_t rd2_mem_o,
    output ex_pkg::word_t     wdata1_mem_o,
    output ex_pkg::word_t     wdata2_mem_o
);

    import ex_pkg::*;

    logic clear;

    // a stall in ex only inserts a bubble when mem is moving
    assign clear = rst_i || flush_i || (pause_ex_i && !pause_mem_i);

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            valid_mem_o  <= 2'b00;
            we_mem_o     <= 2'b00;
            pc1_mem_o    <= '0;
            pc2_mem_o    <= '0;
            op1_mem_o    <= NOP;
            op2_mem_o    <= NOP;
            rd1_mem_o    <= '0;
            rd2_mem_o    <= '0;
            wdata1_mem_o <= '0;
            wdata2_mem_o <= '0;
        end
        else if (!pause_mem_i)
        begin
            valid_mem_o[0] <= valid_i[0];
            we_mem_o[0]    <= we1_i;
            pc1_mem_o      <= pc1_i;
            op1_mem_o      <= op1_i;
            rd1_mem_o      <= rd1_i;
            wdata1_mem_o   <= wdata1_i;

            // lane 2 is off the real path after a lane 1 branch
            valid_mem_o[1] <= valid_i[1] && !squash2_i;
            we_mem_o[1]    <= we2_i && !squash2_i;
            pc2_mem_o      <= squash2_i ? '0 : pc2_i;
            op2_mem_o      <= squash2_i ? NOP : op2_i;
            rd2_mem_o      <= squash2_i ? '0 : rd2_i;
            wdata2_mem_o   <= squash2_i ? '0 : wdata2_i;
        end
    end

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  ex_pkg::word_t     pc1_i,
    input  ex_pkg::alu_op_e   op1_i,
    input  ex_pkg::word_t     src1_1_i,
    input  ex_pkg::word_t     src2_1_i,
    input  ex_pkg::word_t     imm1_i,
    input  ex_pkg::reg_addr_t rd1_i,
    input  logic              we1_i,
    input  logic              pred_taken1_i,
    input  ex_pkg::word_t     pred_target1_i,
    input  ex_pkg::word_t     pc2_i,
    input  ex_pkg::alu_op_e   op2_i,
    input  ex_pkg::word_t     src1_2_i,
    input  ex_pkg::word_t     src2_2_i,
    input  ex_pkg::word_t     imm2_i,
    input  ex_pkg::reg_addr_t rd2_i,
    input  logic              we2_i,
    input  logic              pred_taken2_i,
    input  ex_pkg::word_t     pred_target2_i,
    input  logic [1:0]        valid_i,
    input  logic              flush_i,
    input  logic              pause_mem_i,
    output logic              pause_ex_o,
    output logic              branch_flush_o,
    output ex_pkg::word_t     branch_target_o,
    output logic [1:0]        valid_mem_o,
    output logic [1:0]        we_mem_o,
    output ex_pkg::word_t     pc1_mem_o,
    output ex_pkg::word_t     pc2_mem_o,
    output ex_pkg::alu_op_e   op1_mem_o,
    output ex_pkg::alu_op_e   op2_mem_o,
    output ex_pkg::reg_addr_t rd1_mem_o,
    output ex_pkg::reg_addr_t rd2_mem_o,
    output ex_pkg::word_t     wdata1_mem_o,
    output ex_pkg::word_t     wdata2_mem_o
);

    import ex_pkg::*;

    word_t result1;
    word_t result2;
    word_t next_pc1;
    word_t next_pc2;
    logic  redirect1;
    logic  redirect2;
    logic  is_div1;
    logic  is_div2;
    logic  div_req;
    logic  div_start;
    logic  div_step;
    logic  div_done;
    logic  div_last;
    word_t quotient;
    word_t remainder;
    word_t wdata1;
    logic  squash2;
    logic  valid2;
    logic  we2;

    alu_lane u_lane1 (
        .pc_i          (pc1_i),
        .op_i          (op1_i),
        .src1_i        (src1_1_i),
        .src2_i        (src2_1_i),
        .imm_i         (imm1_i),
        .valid_i       (valid_i[0]),
        .pred_taken_i  (pred_taken1_i),
        .pred_target_i (pred_target1_i),
        .result_o      (result1),
        .next_pc_o     (next_pc1),
        .target_o      (),
        .redirect_o    (redirect1)
    );

    alu_lane u_lane2 (
        .pc_i          (pc2_i),
        .op_i          (op2_i),
        .src1_i        (src1_2_i),
        .src2_i        (src2_2_i),
        .imm_i         (imm2_i),
        .valid_i       (valid_i[1]),
        .pred_taken_i  (pred_taken2_i),
        .pred_target_i (pred_target2_i),
        .result_o      (result2),
        .next_pc_o     (next_pc2),
        .target_o      (),
        .redirect_o    (redirect2)
    );

    assign is_div1 = (op1_i == DIVU) || (op1_i == REMU);
    assign is_div2 = (op2_i == DIVU) || (op2_i == REMU);
    assign div_req = valid_i[0] && is_div1;

    div_fsm u_div_fsm (
        .clk         (clk),
        .rst_i       (rst_i),
        .div_req_i   (div_req),
        .last_i      (div_last),
        .pause_mem_i (pause_mem_i),
        .start_o     (div_start),
        .step_o      (div_step),
        .done_o      (div_done),
        .pause_o     (pause_ex_o)
    );

    div_counter u_div_counter (
        .clk    (clk),
        .rst_i  (rst_i),
        .load_i (div_start),
        .step_i (div_step),
        .last_o (div_last)
    );

    div_datapath u_div_datapath (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (div_start),
        .step_i      (div_step),
        .dividend_i  (src1_1_i),
        .divisor_i   (src2_1_i),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    // divide result only exists in the done cycle
    always_comb
    begin
        if (is_div1 && div_done)
            wdata1 = (op1_i == REMU) ? remainder : quotient;
        else
            wdata1 = result1;
    end

    // lane 2 sits on the wrong path if lane 1 does not fall into it
    assign squash2 = valid_i[0] && (next_pc1 != pc2_i);

    assign branch_flush_o  = (redirect1 || (redirect2 && !squash2))
                             && !pause_ex_o && !pause_mem_i;
    assign branch_target_o = redirect1 ? next_pc1 : next_pc2;

    // no divider on lane 2, drop the op
    assign valid2 = valid_i[1] && !is_div2;
    assign we2    = we2_i && !is_div2;

    ex_mem_reg u_ex_mem_reg (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .pause_mem_i  (pause_mem_i),
        .pause_ex_i   (pause_ex_o),
        .squash2_i    (squash2),
        .valid_i      ({valid2, valid_i[0]}),
        .pc1_i        (pc1_i),
        .pc2_i        (pc2_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .rd1_i        (rd1_i),
        .rd2_i        (rd2_i),
        .we1_i        (we1_i),
        .we2_i        (we2),
        .wdata1_i     (wdata1),
        .wdata2_i     (result2),
        .valid_mem_o  (valid_mem_o),
        .we_mem_o     (we_mem_o),
        .pc1_mem_o    (pc1_mem_o),
        .pc2_mem_o    (pc2_mem_o),
        .op1_mem_o    (op1_mem_o),
        .op2_mem_o    (op2_mem_o),
        .rd1_mem_o    (rd1_mem_o),
        .rd2_mem_o    (rd2_mem_o),
        .wdata1_mem_o (wdata1_mem_o),
        .wdata2_mem_o (wdata2_mem_o)
    );

endmodule

// File: dv/ex_stage_tb.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage_tb;

    import ex_pkg::*;

    localparam int         CLK_PERIOD = 20;
    localparam logic [1:0] MODE_ALU   = 2'd0;
    localparam logic [1:0] MODE_DIV   = 2'd1;
    localparam logic [1:0] MODE_FLUSH = 2'd2;

    typedef struct packed {
        logic [1:0] mode;
        logic       hold;    // pause_mem_i high at the start of the test
        logic       flush;
        logic [1:0] valid;
        alu_op_e    op1;
        alu_op_e    op2;
        word_t      pc1;
        word_t      pc2;
        word_t      a1;
        word_t      b1;
        word_t      a2;
        word_t      b2;
        word_t      imm1;
        word_t      imm2;
        logic       pt1;
        logic       pt2;
        word_t      ptgt1;
        word_t      ptgt2;
        reg_addr_t  rd1;
        reg_addr_t  rd2;
        logic       we1;
        logic       we2;
    } stim_t;

    typedef struct packed {
        logic       flush;
        word_t      target;
        logic [1:0] valid;
        logic [1:0] we;
        word_t      pc1;
        word_t      pc2;
        alu_op_e    op1;
        alu_op_e    op2;
        reg_addr_t  rd1;
        reg_addr_t  rd2;
        word_t      wd1;
        word_t      wd2;
    } expect_t;

    logic       clk = 1'b0;
    logic       rst_i;
    word_t      pc1_i;
    word_t      src1_1_i;
    word_t      src2_1_i;
    word_t      imm1_i;
    word_t      pred_target1_i;
    word_t      pc2_i;
    word_t      src1_2_i;
    word_t      src2_2_i;
    word_t      imm2_i;
    word_t      pred_target2_i;
    alu_op_e    op1_i;
    alu_op_e    op2_i;
    reg_addr_t  rd1_i;
    reg_addr_t  rd2_i;
    logic       we1_i;
    logic       we2_i;
    logic       pred_taken1_i;
    logic       pred_taken2_i;
    logic [1:0] valid_i;
    logic       flush_i;
    logic       pause_mem_i;
    logic       pause_ex_o;
    logic       branch_flush_o;
    word_t      branch_target_o;
    logic [1:0] valid_mem_o;
    logic [1:0] we_mem_o;
    word_t      pc1_mem_o;
    word_t      pc2_mem_o;
    word_t      wdata1_mem_o;
    word_t      wdata2_mem_o;
    alu_op_e    op1_mem_o;
    alu_op_e    op2_mem_o;
    reg_addr_t  rd1_mem_o;
    reg_addr_t  rd2_mem_o;

    string   names[$];
    stim_t   stims[$];
    expect_t exps[$];
    expect_t exp_cur;   // what the bundle should hold right now
    expect_t zero_exp;
    logic    table_ready = 1'b0;
    int      err_count   = 0;
    int      pass_count  = 0;
    int      fail_count  = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ex_stage u_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .pc1_i           (pc1_i),
        .op1_i           (op1_i),
        .src1_1_i        (src1_1_i),
        .src2_1_i        (src2_1_i),
        .imm1_i          (imm1_i),
        .rd1_i           (rd1_i),
        .we1_i           (we1_i),
        .pred_taken1_i   (pred_taken1_i),
        .pred_target1_i  (pred_target1_i),
        .pc2_i           (pc2_i),
        .op2_i           (op2_i),
        .src1_2_i        (src1_2_i),
        .src2_2_i        (src2_2_i),
        .imm2_i          (imm2_i),
        .rd2_i           (rd2_i),
        .we2_i           (we2_i),
        .pred_taken2_i   (pred_taken2_i),
        .pred_target2_i  (pred_target2_i),
        .valid_i         (valid_i),
        .flush_i         (flush_i),
        .pause_mem_i     (pause_mem_i),
        .pause_ex_o      (pause_ex_o),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o),
        .valid_mem_o     (valid_mem_o),
        .we_mem_o        (we_mem_o),
        .pc1_mem_o       (pc1_mem_o),
        .pc2_mem_o       (pc2_mem_o),
        .op1_mem_o       (op1_mem_o),
        .op2_mem_o       (op2_mem_o),
        .rd1_mem_o       (rd1_mem_o),
        .rd2_mem_o       (rd2_mem_o),
        .wdata1_mem_o    (wdata1_mem_o),
        .wdata2_mem_o    (wdata2_mem_o)
    );

    function automatic word_t model_alu(alu_op_e op, word_t a, word_t b, word_t pc);
        word_t r;
        case (op)
            ADD:  r = a + b;
            SUB:  r = a - b;
            AND:  r = a & b;
            OR:   r = a | b;
            XOR:  r = a ^ b;
            SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU: r = (a < b) ? 32'd1 : 32'd0;
            SLL:  r = a << b[4:0];
            SRL:  r = a >> b[4:0];
            SRA:  r = word_t'($signed(a) >>> b[4:0]);
            JAL:  r = pc + `EX_INST_BYTES;
            default: r = '0;   // branches write nothing and divides come from the divider
        endcase
        return r;
    endfunction

    function automatic word_t model_div(alu_op_e op, word_t a, word_t b);
        if (op == DIVU)
            return (b == '0) ? '1 : a / b;
        return (b == '0) ? a : a % b;
    endfunction

    function automatic logic model_taken(alu_op_e op, word_t a, word_t b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            JAL:     return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic expect_t model_expect(stim_t s);
        expect_t e;
        logic    t1;
        logic    t2;
        logic    red1;
        logic    red2;
        logic    squash;
        logic    div2;
        word_t   np1;
        word_t   np2;
        e  = '0;
        t1 = model_taken(s.op1, s.a1, s.b1);
        t2 = model_taken(s.op2, s.a2, s.b2);
        np1 = t1 ? (s.pc1 + s.imm1) : (s.pc1 + `EX_INST_BYTES);
        np2 = t2 ? (s.pc2 + s.imm2) : (s.pc2 + `EX_INST_BYTES);
        red1 = s.valid[0] && (s.op1 inside {BEQ, BNE, BLT, JAL})
               && ((t1 != s.pt1) || (t1 && ((s.pc1 + s.imm1) != s.ptgt1)));
        red2 = s.valid[1] && (s.op2 inside {BEQ, BNE, BLT, JAL})
               && ((t2 != s.pt2) || (t2 && ((s.pc2 + s.imm2) != s.ptgt2)));
        squash = s.valid[0] && (np1 != s.pc2);
        div2   = s.op2 inside {DIVU, REMU};
        e.flush    = red1 || (red2 && !squash);
        e.target   = red1 ? np1 : np2;
        e.valid[0] = s.valid[0];
        e.we[0]    = s.we1;
        e.pc1      = s.pc1;
        e.op1      = s.op1;
        e.rd1      = s.rd1;
        if (s.op1 inside {DIVU, REMU})
            e.wd1 = model_div(s.op1, s.a1, s.b1);
        else
            e.wd1 = model_alu(s.op1, s.a1, s.b1, s.pc1);
        if (!squash)   // squashed lane 2 stays all zero
        begin
            e.valid[1] = s.valid[1] && !div2;
            e.we[1]    = s.we2 && !div2;
            e.pc2      = s.pc2;
            e.op2      = s.op2;
            e.rd2      = s.rd2;
            e.wd2      = model_alu(s.op2, s.a2, s.b2, s.pc2);
        end
        return e;
    endfunction

    // both lanes valid, lane 2 on the sequential path, nothing predicted taken
    function automatic stim_t rand_stim();
        stim_t s;
        s       = '0;
        s.mode  = MODE_ALU;
        s.valid = 2'b11;
        s.pc1   = word_t'($urandom) & 32'hFFFF_FFFC;
        s.pc2   = s.pc1 + `EX_INST_BYTES;
        s.a1    = word_t'($urandom);
        s.b1    = word_t'($urandom);
        s.a2    = word_t'($urandom);
        s.b2    = word_t'($urandom);
        s.imm1  = word_t'($urandom) & 32'h0000_03FC;
        s.imm2  = word_t'($urandom) & 32'h0000_03FC;
        s.rd1   = reg_addr_t'($urandom);
        s.rd2   = reg_addr_t'($urandom);
        s.we1   = 1'b1;
        s.we2   = 1'b1;
        return s;
    endfunction

    // lane 2 carries a mispredicted beq that must stay masked while paused
    function automatic stim_t div_stim(alu_op_e op, word_t a, word_t b);
        stim_t s;
        s       = rand_stim();
        s.mode  = MODE_DIV;
        s.op1   = op;
        s.a1    = a;
        s.b1    = b;
        s.op2   = BEQ;
        s.b2    = ~s.a2;
        s.pt2   = 1'b1;
        s.ptgt2 = s.pc2 + s.imm2;
        return s;
    endfunction

    task automatic add_test(string name, stim_t s);
        names.push_back(name);
        stims.push_back(s);
        exps.push_back(model_expect(s));
    endtask

    task automatic check_word(string test, string what, word_t exp, word_t act);
        if (act !== exp)
        begin
            $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(string test, string what, logic exp, logic act);
        if (act !== exp)
        begin
            $display("ERR %s %s: expected %b, actual %b", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_op(string test, string what, alu_op_e exp, alu_op_e act);
        if (act !== exp)
        begin
            $display("ERR %s %s: expected %s, actual %s", test, what, exp.name(), act.name());
            err_count++;
        end
    endtask

    task automatic check_reg(string test, string what, reg_addr_t exp, reg_addr_t act);
        if (act !== exp)
        begin
            $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bundle(string test, expect_t e);
        check_bit(test, "valid_mem_o[0]", e.valid[0], valid_mem_o[0]);
        check_bit(test, "valid_mem_o[1]", e.valid[1], valid_mem_o[1]);
        check_bit(test, "we_mem_o[0]", e.we[0], we_mem_o[0]);
        check_bit(test, "we_mem_o[1]", e.we[1], we_mem_o[1]);
        check_word(test, "pc1_mem_o", e.pc1, pc1_mem_o);
        check_word(test, "pc2_mem_o", e.pc2, pc2_mem_o);
        check_op(test, "op1_mem_o", e.op1, op1_mem_o);
        check_op(test, "op2_mem_o", e.op2, op2_mem_o);
        check_reg(test, "rd1_mem_o", e.rd1, rd1_mem_o);
        check_reg(test, "rd2_mem_o", e.rd2, rd2_mem_o);
        check_word(test, "wdata1_mem_o", e.wd1, wdata1_mem_o);
        check_word(test, "wdata2_mem_o", e.wd2, wdata2_mem_o);
    endtask

    task automatic check_branch(string test, expect_t e);
        check_bit(test, "branch_flush_o", e.flush, branch_flush_o);
        check_word(test, "branch_target_o", e.target, branch_target_o);
    endtask

    task automatic drive(stim_t s, logic pause_mem);
        pc1_i          = s.pc1;
        op1_i          = s.op1;
        src1_1_i       = s.a1;
        src2_1_i       = s.b1;
        imm1_i         = s.imm1;
        rd1_i          = s.rd1;
        we1_i          = s.we1;
        pred_taken1_i  = s.pt1;
        pred_target1_i = s.ptgt1;
        pc2_i          = s.pc2;
        op2_i          = s.op2;
        src1_2_i       = s.a2;
        src2_2_i       = s.b2;
        imm2_i         = s.imm2;
        rd2_i          = s.rd2;
        we2_i          = s.we2;
        pred_taken2_i  = s.pt2;
        pred_target2_i = s.ptgt2;
        valid_i        = s.valid;
        flush_i        = s.flush;
        pause_mem_i    = pause_mem;
    endtask

    task automatic run_alu(string name, stim_t s, expect_t e);
        @(posedge clk);
        #2;
        drive(s, s.hold);
        if (s.hold)
        begin
            repeat (3)
            begin
                @(negedge clk);
                check_bit(name, "branch_flush_o", 1'b0, branch_flush_o);
                check_bundle(name, exp_cur);
            end
            @(posedge clk);
            #2;
            pause_mem_i = 1'b0;
        end
        @(negedge clk);
        check_bit(name, "pause_ex_o", 1'b0, pause_ex_o);
        check_branch(name, e);
        @(negedge clk);
        if (s.mode == MODE_FLUSH)
            exp_cur = zero_exp;
        else
            exp_cur = e;
        check_bundle(name, exp_cur);
    endtask

    task automatic run_div(string name, stim_t s, expect_t e);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #2;
        drive(s, s.hold);
        @(negedge clk);
        while ((pause_ex_o === 1'b1) && (cycles <= 2 * `EX_DIV_ITERS))
        begin
            cycles++;
            check_bit(name, "branch_flush_o", 1'b0, branch_flush_o);
            if (s.hold)
                check_bundle(name, exp_cur);
            else if (cycles > 1)   // first cycle still shows the older bundle
                check_bundle(name, zero_exp);
            @(negedge clk);
        end
        if (cycles != `EX_DIV_ITERS + 1)
        begin
            $display("%s: pause_ex_o was high for %0d cycles instead of %0d",
                     name, cycles, `EX_DIV_ITERS + 1);
            err_count++;
        end
        if (s.hold)
        begin
            repeat (3)
            begin
                check_bit(name, "pause_ex_o", 1'b0, pause_ex_o);
                check_bit(name, "branch_flush_o", 1'b0, branch_flush_o);
                check_bundle(name, exp_cur);
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            pause_mem_i = 1'b0;
            @(negedge clk);
        end
        check_bit(name, "pause_ex_o", 1'b0, pause_ex_o);
        check_branch(name, e);
        @(posedge clk);
        #2;
        drive(stim_t'('0), 1'b0);   // dispatch moves on
        @(negedge clk);
        check_bundle(name, e);
        exp_cur = zero_exp;   // idle inputs land at the next edge
    endtask

    task automatic report_test(string name, int errs_before);
        if (err_count == errs_before)
        begin
            $display("PASS %s", name);
            pass_count++;
        end
        else
        begin
            $display("FAIL %s", name);
            fail_count++;
        end
    endtask

    task automatic build_table();
        stim_t   s;
        alu_op_e op;
        op = ADD;
        repeat (10)
        begin
            s     = rand_stim();
            s.op1 = op;
            s.op2 = op;
            add_test($sformatf("alu_%s", op.name()), s);
            op = op.next();
        end
        s = rand_stim();
        add_test("alu_NOP", s);

        s       = rand_stim();
        s.op1   = BEQ;
        s.b1    = s.a1;
        s.pt1   = 1'b1;
        s.ptgt1 = s.pc1 + s.imm1;
        s.pc2   = s.ptgt1;   // lane 2 sits at the taken target
        add_test("beq_taken_predicted", s);
        s     = rand_stim();
        s.op1 = BNE;
        s.b1  = s.a1;
        add_test("bne_not_taken_predicted", s);
        s     = rand_stim();
        s.op1 = BLT;
        s.a1  = 32'd3;
        s.b1  = 32'hFFFF_FFFF;
        add_test("blt_signed_not_taken", s);
        s     = rand_stim();
        s.op1 = BLT;
        s.a1  = 32'hFFFF_FFF0;
        s.b1  = 32'd5;
        add_test("blt_taken_mispredict", s);
        s       = rand_stim();
        s.op1   = BEQ;
        s.b1    = ~s.a1;
        s.pt1   = 1'b1;
        s.ptgt1 = s.pc1 + s.imm1;
        add_test("beq_not_taken_mispredict", s);
        s       = rand_stim();
        s.op1   = JAL;
        s.pt1   = 1'b1;
        s.ptgt1 = s.pc1 + s.imm1 + 32'd8;
        add_test("jal_wrong_target", s);
        s     = rand_stim();
        s.op2 = BNE;
        s.b2  = ~s.a2;
        add_test("lane2_mispredict", s);
        s       = rand_stim();
        s.op1   = BEQ;
        s.b1    = s.a1;
        s.op2   = BNE;
        s.b2    = ~s.a2;
        add_test("both_mispredict", s);
        s     = rand_stim();
        s.pc2 = s.pc1 + 32'd8;
        s.op2 = BNE;
        s.b2  = ~s.a2;
        add_test("lane2_squashed_no_redirect", s);
        s       = rand_stim();
        s.valid = 2'b10;
        s.op1   = BEQ;
        s.b1    = s.a1;
        s.pc2   = s.pc1 + 32'h100;
        add_test("lane1_invalid_branch", s);
        s     = rand_stim();
        s.op2 = DIVU;
        add_test("divu_lane2_dropped", s);

        s      = rand_stim();
        s.op1  = SUB;
        s.op2  = BNE;   // mispredicted, so the flush must stay masked while mem is paused
        s.b2   = ~s.a2;
        s.hold = 1'b1;
        add_test("hold_mem_alu", s);
        s       = rand_stim();
        s.op1   = XOR;
        s.op2   = AND;
        s.flush = 1'b1;
        s.mode  = MODE_FLUSH;
        add_test("flush_bundle", s);

        add_test("divu_random",
                 div_stim(DIVU, word_t'($urandom), word_t'($urandom_range(1, 1000))));
        add_test("remu_random",
                 div_stim(REMU, word_t'($urandom), word_t'($urandom_range(1, 1000))));
        add_test("divu_zero", div_stim(DIVU, word_t'($urandom), '0));
        add_test("remu_zero", div_stim(REMU, word_t'($urandom), '0));
        add_test("divu_all_ones", div_stim(DIVU, 32'hFFFF_FFFF, 32'd7));
        s     = rand_stim();
        s.op1 = ADD;
        s.op2 = SLTU;
        add_test("alu_after_div", s);
        s      = div_stim(DIVU, word_t'($urandom), word_t'($urandom_range(1, 50)));
        s.hold = 1'b1;
        add_test("divu_mem_hold", s);
    endtask

    initial
    begin
        int errs_before;
        void'($urandom(73152));
        rst_i    = 1'b1;
        zero_exp = '0;
        exp_cur  = '0;
        drive(stim_t'('0), 1'b0);
        build_table();
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        #2;
        rst_i = 1'b0;
        errs_before = err_count;
        @(negedge clk);
        check_bit("reset", "valid_mem_o[0]", 1'b0, valid_mem_o[0]);
        check_bit("reset", "valid_mem_o[1]", 1'b0, valid_mem_o[1]);
        check_bit("reset", "we_mem_o[0]", 1'b0, we_mem_o[0]);
        check_bit("reset", "we_mem_o[1]", 1'b0, we_mem_o[1]);
        check_bit("reset", "pause_ex_o", 1'b0, pause_ex_o);
        check_bit("reset", "branch_flush_o", 1'b0, branch_flush_o);
        report_test("reset", errs_before);

        for (int i = 0; i < stims.size(); i++)
        begin
            errs_before = err_count;
            if (stims[i].mode == MODE_DIV)
                run_div(names[i], stims[i], exps[i]);
            else
                run_alu(names[i], stims[i], exps[i]);
            report_test(names[i], errs_before);
        end

        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 pass_count + fail_count, pass_count, fail_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // budget of 40 cycles per test plus reset
    initial
    begin
        wait (table_ready);
        #(((stims.size() + 1) * 40 + 8) * CLK_PERIOD);
        $display("timeout: the tests did not finish within their cycle budget");
        $display("Errors found");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/alu_lane.sv
hdl/div_fsm.sv
hdl/div_counter.sv
hdl/div_datapath.sv
hdl/ex_mem_reg.sv
hdl/ex_stage.sv
dv/ex_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ex_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sources.f \
    --top-module ex_stage_tb \
    -Mdir obj_dir \
    -o ex_stage_tb_sim

./obj_dir/ex_stage_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi

echo "simulation passed"
